// File: verilog/cache_geom_pkg.sv
package cache_geom_pkg;

  ////////////////////
  // word and address
  ////////////////////

  localparam int DATA_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 12;
  localparam int BYTE_OFF    = 2;  // ignored, one word per line
  localparam int INDEX_WIDTH = 4;
  localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - BYTE_OFF;  // 6 bits

  localparam int CACHE_DEPTH = 2 ** INDEX_WIDTH;  // 16 lines

  // field split of a physical address, high to low
  typedef struct packed {
    logic [TAG_WIDTH-1:0]   tag;
    logic [INDEX_WIDTH-1:0] index;
    logic [BYTE_OFF-1:0]    byte_off;
  } phys_addr_fields_t;

  // cpu side writes raw, cache side reads fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    phys_addr_fields_t     fields;
  } phys_addr_u;

endpackage

// File: verilog/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // word address into backing memory is tag plus index
  localparam int MEM_AWIDTH = cache_geom_pkg::TAG_WIDTH + cache_geom_pkg::INDEX_WIDTH;
  localparam int MEM_DEPTH  = 2 ** MEM_AWIDTH;  // 1024 words

  // cycles from first enable to the ready pulse
  localparam int MEM_LATENCY = 3;

  // width of the latency counter
  localparam int LAT_CNT_WIDTH = $clog2(MEM_LATENCY + 1);

endpackage

// File: verilog/mem_if.sv
`timescale 1ns/10ps

interface mem_if;
  import cache_geom_pkg::*;
  import mem_cfg_pkg::*;

  logic                  wren;
  logic                  rden;
  logic [MEM_AWIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;  // valid from ready until next request
  logic                  ready;  // one cycle pulse

  // cache side
  modport ctrl (
    output wren, rden, addr, wdata,
    input  rdata, ready
  );

  // memory model side
  modport mem (
    input  wren, rden, addr, wdata,
    output rdata, ready
  );

endinterface

// File: verilog/tag_if.sv
`timescale 1ns/10ps

interface tag_if;
  import cache_geom_pkg::*;

  // line select and lookup tag, from the address slice
  logic [INDEX_WIDTH-1:0] index;
  logic [TAG_WIDTH-1:0]   tag;

  // update strobes from the fsm
  logic                   set_valid;    // writes valid and dirty of the line
  logic                   set_dirty;    // value written to the dirty bit
  logic                   replace_tag;  // loads tag into the line

  // lookup results
  logic                   hit;
  logic                   dirty;
  logic [TAG_WIDTH-1:0]   tag_old;      // stored tag, used for writeback address

  modport ctrl (
    output set_valid, set_dirty, replace_tag,
    input  hit, dirty, tag_old
  );

  modport array (
    input  index, tag, set_valid, set_dirty, replace_tag,
    output hit, dirty, tag_old
  );

endinterface

// File: verilog/tag_array.sv
`timescale 1ns/10ps

module tag_array (
  input  logic clk,
  input  logic arst_n,
  tag_if.array tag_bus
);
  import cache_geom_pkg::*;

  logic [CACHE_DEPTH-1:0] valid_q;
  logic [CACHE_DEPTH-1:0] dirty_q;
  logic [TAG_WIDTH-1:0]   tag_q [CACHE_DEPTH];

  ////////////////////
  // lookup
  ////////////////////

  assign tag_bus.tag_old = tag_q[tag_bus.index];

  // match only counts on a valid line
  assign tag_bus.hit = valid_q[tag_bus.index] && (tag_q[tag_bus.index] == tag_bus.tag);

  // stale dirty bits of invalid lines are masked
  assign tag_bus.dirty = valid_q[tag_bus.index] && dirty_q[tag_bus.index];

  ////////////////////
  // update
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (tag_bus.set_valid) begin
      valid_q[tag_bus.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_bus.set_valid) begin
      dirty_q[tag_bus.index] <= tag_bus.set_dirty;  // cleared on fill, set on write hit
    end
    if (tag_bus.replace_tag) begin
      tag_q[tag_bus.index] <= tag_bus.tag;
    end
  end

endmodule

// File: verilog/data_array.sv
`timescale 1ns/10ps

module data_array (
  input  logic                                 clk,
  input  logic                                 wren,
  input  logic                                 rden,
  input  logic [cache_geom_pkg::INDEX_WIDTH-1:0] index,
  input  logic [cache_geom_pkg::DATA_WIDTH-1:0]  data_in,
  output logic [cache_geom_pkg::DATA_WIDTH-1:0]  data_out
);
  import cache_geom_pkg::*;

  logic [DATA_WIDTH-1:0] line_q [CACHE_DEPTH];

  always_ff @(posedge clk) begin
    if (wren) begin
      line_q[index] <= data_in;
    end
  end

  // registered read, holds when rden is low
  always_ff @(posedge clk) begin
    if (rden) begin
      if (wren) begin
        data_out <= data_in;  // write first, fill data shows up next cycle
      end else begin
        data_out <= line_q[index];
      end
    end
  end

endmodule

// File: verilog/backing_mem.sv
`timescale 1ns/10ps

module backing_mem (
  input  logic clk,
  input  logic arst_n,
  mem_if.mem   mem_bus
);
  import cache_geom_pkg::*;
  import mem_cfg_pkg::*;

  logic [DATA_WIDTH-1:0]    word_q [MEM_DEPTH] = '{default: '0};
  logic                     busy_q;
  logic [LAT_CNT_WIDTH-1:0] cnt_q;
  logic                     req;
  logic                     last;

  assign req  = mem_bus.wren || mem_bus.rden;
  assign last = busy_q && (cnt_q == LAT_CNT_WIDTH'(MEM_LATENCY - 1));  // ready next cycle

  ////////////////////
  // latency counter
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q        <= 1'b0;
      cnt_q         <= '0;
      mem_bus.ready <= 1'b0;
    end else begin
      mem_bus.ready <= last;
      if (last) begin
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (req && !mem_bus.ready) begin
        // enable still high during ready must not restart
        busy_q <= 1'b1;
        cnt_q  <= LAT_CNT_WIDTH'(1);
      end
    end
  end

  ////////////////////
  // storage access
  ////////////////////

  // done on the edge that raises ready
  always_ff @(posedge clk) begin
    if (last) begin
      if (mem_bus.wren) begin
        word_q[mem_bus.addr] <= mem_bus.wdata;
      end else begin
        mem_bus.rdata <= word_q[mem_bus.addr];
      end
    end
  end

endmodule

// File: verilog/cache_fsm.sv
`timescale 1ns/10ps

module cache_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic cpu_wren,
  input  logic cpu_rden,
  mem_if.ctrl  mem_bus,
  tag_if.ctrl  tag_bus,
  output logic cache_wren,
  output logic cache_rden,
  output logic cache_insel,
  output logic tag_sel,
  output logic stall
);

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    ALLOCATE,
    FILL
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   cpu_req;
  logic   done;

  assign cpu_req = cpu_wren || cpu_rden;

  // an access completes only on a hit in compare
  assign done  = (state_q == COMPARE) && tag_bus.hit;
  assign stall = cpu_req && !done;

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // next state and strobes
  ////////////////////

  always_comb begin
    state_d             = state_q;
    cache_wren          = 1'b0;
    cache_rden          = 1'b0;
    cache_insel         = 1'b0;  // cpu data into the line
    tag_sel             = 1'b0;  // current tag on mem addr
    mem_bus.wren        = 1'b0;
    mem_bus.rden        = 1'b0;
    tag_bus.set_valid   = 1'b0;
    tag_bus.set_dirty   = 1'b0;
    tag_bus.replace_tag = 1'b0;

    case (state_q)
      IDLE: begin
        if (cpu_req) begin
          cache_rden = 1'b1;  // line data ready in compare
          state_d    = COMPARE;
        end
      end

      COMPARE: begin
        if (!cpu_req) begin
          state_d = IDLE;
        end else if (tag_bus.hit) begin
          if (cpu_wren) begin
            cache_wren        = 1'b1;
            tag_bus.set_valid = 1'b1;
            tag_bus.set_dirty = 1'b1;
          end
          state_d = IDLE;
        end else if (tag_bus.dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = ALLOCATE;
        end
      end

      // data_out still holds the victim line read in idle
      WRITEBACK: begin
        mem_bus.wren = 1'b1;
        tag_sel      = 1'b1;
        if (mem_bus.ready) begin
          state_d = ALLOCATE;
        end
      end

      ALLOCATE: begin
        mem_bus.rden = 1'b1;
        if (mem_bus.ready) begin
          state_d = FILL;
        end
      end

      FILL: begin
        cache_insel         = 1'b1;  // memory rdata into the line
        cache_wren          = 1'b1;
        cache_rden          = 1'b1;  // refresh data_out for compare
        tag_bus.replace_tag = 1'b1;
        tag_bus.set_valid   = 1'b1;
        tag_bus.set_dirty   = 1'b0;  // clean after refill
        state_d             = COMPARE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule

// File: verilog/data_cache.sv
`timescale 1ns/10ps

module data_cache (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cpu_wren,
  input  logic                                cpu_rden,
  input  logic [cache_geom_pkg::ADDR_WIDTH-1:0] phys_addr,
  input  logic [cache_geom_pkg::DATA_WIDTH-1:0] cpu_data_in,
  output logic [cache_geom_pkg::DATA_WIDTH-1:0] cpu_data_out,
  output logic                                cpu_stall
);
  import cache_geom_pkg::*;
  import mem_cfg_pkg::*;

  phys_addr_u            addr_u;
  logic [MEM_AWIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] cache_data_in;
  logic [DATA_WIDTH-1:0] cache_data_out;

  logic fsm_cache_wren;
  logic fsm_cache_rden;
  logic fsm_cache_insel;
  logic fsm_tag_sel;

  mem_if mem_bus ();
  tag_if tag_bus ();

  ////////////////////
  // address slice
  ////////////////////

  assign addr_u.raw    = phys_addr;
  assign tag_bus.index = addr_u.fields.index;
  assign tag_bus.tag   = addr_u.fields.tag;  // byte offset dropped

  // victim tag during writeback, lookup tag otherwise
  assign mem_addr = fsm_tag_sel ? {tag_bus.tag_old, addr_u.fields.index}
                                : {addr_u.fields.tag, addr_u.fields.index};

  ////////////////////
  // data paths
  ////////////////////

  assign cache_data_in = fsm_cache_insel ? mem_bus.rdata : cpu_data_in;
  assign mem_bus.addr  = mem_addr;
  assign mem_bus.wdata = cache_data_out;
  assign cpu_data_out  = cache_data_out;

  tag_array u_tag_array (
    .clk     (clk),
    .arst_n  (arst_n),
    .tag_bus (tag_bus)
  );

  data_array u_data_array (
    .clk      (clk),
    .wren     (fsm_cache_wren),
    .rden     (fsm_cache_rden),
    .index    (addr_u.fields.index),
    .data_in  (cache_data_in),
    .data_out (cache_data_out)
  );

  backing_mem u_backing_mem (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_bus (mem_bus)
  );

  cache_fsm u_cache_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .cpu_wren    (cpu_wren),
    .cpu_rden    (cpu_rden),
    .mem_bus     (mem_bus),
    .tag_bus     (tag_bus),
    .cache_wren  (fsm_cache_wren),
    .cache_rden  (fsm_cache_rden),
    .cache_insel (fsm_cache_insel),
    .tag_sel     (fsm_tag_sel),
    .stall       (cpu_stall)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  localparam real HALF_PERIOD_NS = 2.0;  // 4 ns period

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk = ~clk;
    end
  end

endmodule

// File: verification/data_cache_tb.sv
`timescale 1ns/10ps

module data_cache_tb;
  import cache_geom_pkg::*;
  import mem_cfg_pkg::*;

  localparam int MAX_ENTRIES    = 32;
  localparam int NUM_RANDOM     = 200;
  localparam int WORST_ACCESS   = 2 * (MEM_LATENCY + 1) + 3;  // dirty miss
  localparam int TIMEOUT_CYCLES = (MAX_ENTRIES + NUM_RANDOM) * WORST_ACCESS + 256;

  typedef struct packed {
    logic                  is_write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] exp_data;
    logic [7:0]            exp_cycles;  // 0 means timing not checked
  } access_t;

  logic                  clk;
  logic                  arst_n;
  logic                  cpu_wren;
  logic                  cpu_rden;
  logic [ADDR_WIDTH-1:0] phys_addr;
  logic [DATA_WIDTH-1:0] cpu_data_in;
  logic [DATA_WIDTH-1:0] cpu_data_out;
  logic                  cpu_stall;

  access_t               table_q [MAX_ENTRIES];
  int                    n_entries = 0;
  logic [DATA_WIDTH-1:0] model_q [MEM_DEPTH];  // word addressed reference memory
  int                    n_tests = 0;
  int                    n_failed_tests = 0;
  int                    n_errors = 0;
  int                    cycle_cnt = 0;
  int                    seed = 32'h8af5_6914;

  tb_clock_gen clk_gen_i (
    .clk (clk)
  );

  data_cache dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cpu_wren     (cpu_wren),
    .cpu_rden     (cpu_rden),
    .phys_addr    (phys_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_data_out (cpu_data_out),
    .cpu_stall    (cpu_stall)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic add_entry(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] wdata,
                           input logic [DATA_WIDTH-1:0] exp_data, input int exp_cycles);
    table_q[n_entries] = '{is_write, addr, wdata, exp_data, 8'(exp_cycles)};
    n_entries++;
  endtask

  task automatic load_table();
    add_entry(1'b0, 12'h000, '0, 32'h0000_0000, 0);  // cold reads return zero
    add_entry(1'b0, 12'h3fc, '0, 32'h0000_0000, 0);
    add_entry(1'b1, 12'h040, 32'hdead_0040, '0, 0);
    add_entry(1'b0, 12'h040, '0, 32'hdead_0040, 0);
    add_entry(1'b0, 12'h042, '0, 32'hdead_0040, 0);  // other byte offsets reach the same word
    add_entry(1'b0, 12'h043, '0, 32'hdead_0040, 2);
    // dirty eviction with tags 1 and 2 on index 3
    add_entry(1'b1, 12'h04c, 32'h1111_aaaa, '0, 0);
    add_entry(1'b1, 12'h08c, 32'h2222_bbbb, '0, 0);
    add_entry(1'b0, 12'h04c, '0, 32'h1111_aaaa, 0);
    add_entry(1'b0, 12'h08c, '0, 32'h2222_bbbb, 0);
    // clean conflict with tags 5 and 6 on index 7
    add_entry(1'b0, 12'h15c, '0, 32'h0000_0000, 0);
    add_entry(1'b0, 12'h19c, '0, 32'h0000_0000, 0);
    add_entry(1'b0, 12'h15c, '0, 32'h0000_0000, 0);
    add_entry(1'b0, 12'h15c, '0, 32'h0000_0000, 2);
    add_entry(1'b0, 12'h040, '0, 32'hdead_0040, 0);  // other lines untouched
    add_entry(1'b0, 12'h08c, '0, 32'h2222_bbbb, 2);
    add_entry(1'b1, 12'h040, 32'h0bad_f00d, '0, 2);  // write hit
    add_entry(1'b0, 12'h041, '0, 32'h0bad_f00d, 2);
  endtask

  // hold the request until stall is low and sample the result mid cycle
  task automatic run_access(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata,
                            output logic [DATA_WIDTH-1:0] rdata, output int cycles);
    @(posedge clk);
    cpu_wren    <= is_write;
    cpu_rden    <= !is_write;
    phys_addr   <= addr;
    cpu_data_in <= wdata;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (cpu_stall);
    rdata = cpu_data_out;  // completing edge is the next posedge
  endtask

  task automatic drop_request();
    @(posedge clk);
    cpu_wren <= 1'b0;
    cpu_rden <= 1'b0;
  endtask

  task automatic check_read(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] exp_data,
                            input logic [DATA_WIDTH-1:0] got);
    assert (got === exp_data) else begin
      n_errors++;
      $display("mismatch at %0t: read addr 0x%03h expected 0x%08h got 0x%08h",
               $time, addr, exp_data, got);
    end
  endtask

  task automatic check_idle_stall();
    @(negedge clk);
    assert (cpu_stall === 1'b0) else begin
      n_errors++;
      $display("mismatch at %0t: cpu_stall expected 0 got %b with no request present",
               $time, cpu_stall);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    n_tests++;
    if (n_errors == err_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_failed_tests++;
      $display("test %0d %s: failed", n_tests, name);
    end
  endtask

  ////////////////////
  // watchdog
  ////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d clock cycles, the DUT stopped answering",
               TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [DATA_WIDTH-1:0] got;
    logic [DATA_WIDTH-1:0] wdata;
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           r;
    int                    cycles;
    int                    err_before;

    arst_n      = 1'b0;
    cpu_wren    = 1'b0;
    cpu_rden    = 1'b0;
    phys_addr   = '0;
    cpu_data_in = '0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      model_q[i] = '0;
    end
    load_table();

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    err_before = n_errors;
    check_idle_stall();
    report_test("idle after reset", err_before);

    for (int i = 0; i < n_entries; i++) begin
      err_before = n_errors;
      run_access(table_q[i].is_write, table_q[i].addr, table_q[i].wdata, got, cycles);
      if (table_q[i].is_write) begin
        model_q[table_q[i].addr >> BYTE_OFF] = table_q[i].wdata;
      end else begin
        check_read(table_q[i].addr, table_q[i].exp_data, got);
      end
      if (table_q[i].exp_cycles != 0) begin
        assert (cycles == table_q[i].exp_cycles) else begin
          n_errors++;
          $display("mismatch at %0t: addr 0x%03h completed after %0d cycles, expected %0d",
                   $time, table_q[i].addr, cycles, table_q[i].exp_cycles);
        end
      end
      report_test($sformatf("%s 0x%03h", table_q[i].is_write ? "write" : "read",
                            table_q[i].addr), err_before);
    end

    drop_request();
    err_before = n_errors;
    check_idle_stall();
    report_test("idle after table", err_before);

    // 64 word window where bit 8 picks read or write
    err_before = n_errors;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      r     = $random(seed);
      addr  = ADDR_WIDTH'(r[7:0]);
      wdata = $random(seed);
      run_access(r[8], addr, wdata, got, cycles);
      if (r[8]) begin
        model_q[addr >> BYTE_OFF] = wdata;
      end else begin
        check_read(addr, model_q[addr >> BYTE_OFF], got);
      end
    end
    drop_request();
    report_test("random mixed accesses", err_before);

    $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed_tests,
             n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sim.f
verilog/cache_geom_pkg.sv
verilog/mem_cfg_pkg.sv
verilog/mem_if.sv
verilog/tag_if.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/backing_mem.sv
verilog/cache_fsm.sv
verilog/data_cache.sv
verification/tb_clock_gen.sv
verification/data_cache_tb.sv
